// File: run_sim.sh
#!/bin/sh
# build the sort buffer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

top=sort_buffer_tb
log=sim.log

rm -rf obj_dir "$log"

verilator --binary --timing --assert -Wno-fatal \
	--top-module "$top" -f sort_buffer.f -o "$top" \
	&& ./obj_dir/"$top" 2>&1 | tee "$log"

grep -qs "^Result: PASSED$" "$log" \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see $log"; exit 1; }

// File: sort_buffer.f
verilog/sort_pkg.sv
verilog/sort_key_compare.sv
verilog/sort_idle_timer.sv
verilog/sort_rank_store.sv
verilog/sort_buffer.sv
test/sort_buffer_props.sv
test/sort_buffer_tb.sv

// File: test/sort_buffer_props.sv
`timescale 1ns/1ps

module sort_buffer_props (
	input logic                        clk,
	input logic                        rst_n,
	input logic                        valid_in,
	input logic                        ready,
	input logic [sort_pkg::word_w-1:0] data_out,
	input logic                        valid_out,
	input logic                        full
);

	////////////////////////////////////////
	// output rules

	// a record taken below full is only stored
	insert_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		(ready && valid_in && !full) |=> !valid_out)
	else $error("valid_out pulsed after an insert into a buffer that was not full");

	// stall freezes everything the outside sees
	stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
		!ready |=> ($stable(data_out) && $stable(valid_out) && $stable(full)))
	else $error("an output changed across a cycle with ready low");

	full_keeps: assert property (@(posedge clk) disable iff (!rst_n)
		(valid_in && full) |=> full)
	else $error("full fell while valid_in was high");

endmodule

bind sort_buffer sort_buffer_props sort_buffer_props_inst (
	.clk       (clk),
	.rst_n     (rst_n),
	.valid_in  (valid_in),
	.ready     (ready),
	.data_out  (data_out),
	.valid_out (valid_out),
	.full      (full)
);

// File: test/sort_buffer_tb.sv
`timescale 1ns/1ps

module sort_buffer_tb;

	localparam int clk_period    = 40;
	localparam int reset_cycles  = 5;
	localparam int margin_cycles = 20;   // slack past the last data line
	localparam     data_path     = "test/sort_buffer_testdata.txt";

	logic                 clk;
	logic                 rst_n;
	sort_pkg::sort_word_t data_in;
	logic                 valid_in;
	logic                 ready;
	sort_pkg::sort_word_t data_out;
	logic                 valid_out;
	logic                 full;

	int seed;
	int cycle_count;
	int cycle_limit;
	int line_count;

	sort_buffer sort_buffer_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.data_in   (data_in),
		.valid_in  (valid_in),
		.ready     (ready),
		.data_out  (data_out),
		.valid_out (valid_out),
		.full      (full)
	);

	////////////////////////////////////////
	// clock and watchdog

	always #(clk_period / 2) clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("timeout: the data file was not done after %0d cycles", cycle_limit);
			abort_run("timeout");
		end
	end

	////////////////////////////////////////
	// failure and compare tasks

	task automatic abort_run(input string reason);
		$display("Result: FAILED");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_word(input string name, input sort_pkg::sort_word_t got,
			input sort_pkg::sort_word_t exp, input int file_line);
		if (got.raw !== exp.raw) begin
			$display("CHECK FAILED %s: got 0x%h expected 0x%h (data file line %0d)",
				name, got.raw, exp.raw, file_line);
			abort_run("record mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp,
			input int file_line);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%h expected 0x%h (data file line %0d)",
				name, got, exp, file_line);
			abort_run("valid mismatch");
		end
	endtask

	task automatic check_full(input string name, input logic got, input logic exp,
			input int file_line);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%h expected 0x%h (data file line %0d)",
				name, got, exp, file_line);
			abort_run("full flag mismatch");
		end
	endtask

	task automatic compare_outputs(input logic exp_valid, input sort_pkg::sort_word_t exp_word,
			input logic exp_full, input int file_line);
		check_bit("valid_out", valid_out, exp_valid, file_line);
		check_word("data_out", data_out, exp_word, file_line);
		check_full("full", full, exp_full, file_line);
	endtask

	////////////////////////////////////////
	// data file

	// stimulus lines only, comments and blank lines skipped
	function automatic int count_data_lines();
		int          fd;
		int          n;
		int          lines;
		string       text;
		logic [39:0] first;

		lines = 0;
		fd    = $fopen(data_path, "r");
		if (fd == 0) begin
			return -1;
		end
		while (!$feof(fd)) begin
			n = $fgets(text, fd);
			if (n != 0 && $sscanf(text, "%h", first) == 1) begin
				lines++;
			end
		end
		$fclose(fd);
		return lines;
	endfunction

	task automatic apply_data_file();
		int                   fd;
		int                   n;
		int                   file_line;
		int                   exp_line;
		string                text;
		logic [3:0]           f_valid;
		logic [3:0]           f_ready;
		logic [39:0]          f_data;
		logic [3:0]           f_vout;
		logic [39:0]          f_dout;
		logic [3:0]           f_full;
		logic [31:0]          rnd;
		logic                 pending;
		logic                 exp_valid;
		logic                 exp_full;
		sort_pkg::sort_word_t exp_word;
		sort_pkg::sort_word_t stim;

		pending      = 1'b0;
		file_line    = 0;
		exp_line     = 0;
		exp_valid    = 1'b0;
		exp_full     = 1'b0;
		exp_word.raw = '0;
		fd           = $fopen(data_path, "r");
		while (!$feof(fd)) begin
			n = $fgets(text, fd);
			file_line++;
			if (n != 0) begin
				n = $sscanf(text, "%h %h %h %h %h %h",
					f_valid, f_ready, f_data, f_vout, f_dout, f_full);
				if (n == 6) begin
					@(negedge clk);
					if (pending) begin
						compare_outputs(exp_valid, exp_word, exp_full, exp_line);   // last line's edge
					end
					stim.raw = f_data;
					if (f_valid == 4'h0) begin
						// never taken, so src and tag are free
						rnd        = $random(seed);
						stim.f.src = rnd[3:0];
						stim.f.tag = rnd[5:4];
					end
					data_in      = stim;
					valid_in     = f_valid[0];
					ready        = f_ready[0];
					exp_valid    = f_vout[0];
					exp_word.raw = f_dout;
					exp_full     = f_full[0];
					exp_line     = file_line;
					pending      = 1'b1;
				end else if (n > 0) begin
					$display("data file line %0d holds %0d of the 6 fields", file_line, n);
					abort_run("malformed data file");
				end
			end
		end
		$fclose(fd);
		if (pending) begin
			@(negedge clk);
			compare_outputs(exp_valid, exp_word, exp_full, exp_line);
		end
	endtask

	////////////////////////////////////////
	// main sequence

	initial begin
		clk         = 1'b0;
		rst_n       = 1'b0;
		valid_in    = 1'b0;
		ready       = 1'b0;
		data_in.raw = '0;
		seed        = 32'h7ed5a27c;
		cycle_count = 0;
		cycle_limit = 0;
		line_count  = count_data_lines();
		if (line_count <= 0) begin
			$display("data file %s is missing or holds no stimulus lines", data_path);
			abort_run("no stimulus");
		end
		cycle_limit = line_count + reset_cycles + margin_cycles;

		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		apply_data_file();

		$display("Result: PASSED");
		$finish;
	end

endmodule

// File: test/sort_buffer_testdata.txt
# columns: valid_in ready data_in, then expected valid_out data_out full
# one line per clock, hex, outputs as seen after that line's rising edge
1 1 1000000C01 0 0000000000 0
1 1 2000000402 0 0000000000 0
1 1 3000001403 0 0000000000 0
1 1 4000000800 0 0000000000 0
1 1 5000001001 0 0000000000 1
1 1 6000000202 1 6000000202 1
1 1 7000000D43 1 2000000402 1
1 1 8000001800 1 4000000800 1
1 1 9000001002 1 1000000C01 1
1 1 A000001003 1 7000000D43 1
1 1 B000001000 1 5000001001 1
1 0 C000000041 1 5000001001 1
1 0 C000000041 1 5000001001 1
1 1 C000000041 1 C000000041 1
0 1 0000000000 0 0000000000 1
0 1 0000000000 0 0000000000 1
0 1 0000000000 0 0000000000 1
0 1 0000000000 0 0000000000 1
0 1 0000000000 0 0000000000 1
0 1 0000000000 0 0000000000 1
0 1 0000000000 0 0000000000 1
0 1 0000000000 0 0000000000 1
0 0 0000000000 0 0000000000 1
1 0 D000000005 0 0000000000 1
0 0 0000000000 0 0000000000 1
0 1 0000000000 0 0000000000 1
0 1 0000000000 0 0000000000 1
0 1 0000000000 0 0000000000 1
0 1 0000000000 0 0000000000 1
0 1 0000000000 0 0000000000 1
0 1 0000000000 0 0000000000 1
0 1 0000000000 0 0000000000 1
0 1 0000000000 0 0000000000 1
0 1 0000000000 1 9000001002 0
0 1 0000000000 1 A000001003 0
0 1 0000000000 1 B000001000 0
0 0 0000000000 1 B000001000 0
0 1 0000000000 1 3000001403 0
0 1 0000000000 1 8000001800 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
1 1 100000088A 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
1 1 2000000445 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
1 1 300000088B 0 0000000000 0
1 1 4000000888 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 1 2000000445 0
0 1 0000000000 1 100000088A 0
0 1 0000000000 1 300000088B 0
0 1 0000000000 1 4000000888 0
0 1 0000000000 0 0000000000 0
0 1 0000000000 0 0000000000 0

// File: verilog/sort_buffer.sv
`timescale 1ns/1ps

module sort_buffer (
	input  logic                 clk,
	input  logic                 rst_n,
	input  sort_pkg::sort_word_t data_in,
	input  logic                 valid_in,
	input  logic                 ready,
	output sort_pkg::sort_word_t data_out,
	output logic                 valid_out,
	output logic                 full
);

	sort_pkg::sort_word_t [sort_pkg::depth-1:0] ranks;
	logic [sort_pkg::depth-1:0]                 less_mask;
	logic                                       idle_expired;

	////////////////////////////////////////
	// compare stage, zero latency

	sort_key_compare sort_key_compare_inst (
		.data_in   (data_in),
		.ranks     (ranks),
		.less_mask (less_mask)
	);

	sort_idle_timer sort_idle_timer_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.valid_in     (valid_in),
		.ready        (ready),
		.idle_expired (idle_expired)
	);

	////////////////////////////////////////
	// storage stage, registered output

	sort_rank_store sort_rank_store_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.data_in      (data_in),
		.valid_in     (valid_in),
		.ready        (ready),
		.less_mask    (less_mask),
		.idle_expired (idle_expired),
		.ranks        (ranks),        // fed back to the compare stage
		.data_out     (data_out),
		.valid_out    (valid_out),
		.full         (full)
	);

endmodule

// File: verilog/sort_idle_timer.sv
`timescale 1ns/1ps

module sort_idle_timer (
	input  logic clk,
	input  logic rst_n,
	input  logic valid_in,
	input  logic ready,
	output logic idle_expired
);

	logic [sort_pkg::idle_w-1:0] idle_cnt;
	logic                        at_limit;

	assign at_limit = (int'(idle_cnt) == sort_pkg::idle_limit);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			idle_cnt <= '0;
		end else if (ready) begin
			if (valid_in) begin
				idle_cnt <= '0;                 // any record restarts the wait
			end else if (!at_limit) begin
				idle_cnt <= idle_cnt + 1'b1;
			end
		end
	end

	// stays high once saturated, so the store keeps draining
	assign idle_expired = at_limit;

endmodule

// File: verilog/sort_key_compare.sv
`timescale 1ns/1ps

module sort_key_compare (
	input  sort_pkg::sort_word_t                       data_in,
	input  sort_pkg::sort_word_t [sort_pkg::depth-1:0] ranks,
	output logic [sort_pkg::depth-1:0]                 less_mask
);

	logic [sort_pkg::key_w-1:0] in_key;

	assign in_key = data_in.f.key;

	////////////////////////////////////////
	// one comparator per rank, all in parallel

	// strict compare, so a record with an equal key lands behind the
	// stored one and equal keys leave in arrival order
	genvar i;
	generate
		for (i = 0; i < sort_pkg::depth; i = i + 1) begin : g_cmp
			logic [sort_pkg::key_w-1:0] rank_key;

			assign rank_key     = ranks[i].f.key;
			assign less_mask[i] = (in_key < rank_key);   // stale ranks masked in store
		end
	endgenerate

endmodule

// File: verilog/sort_pkg.sv
package sort_pkg;

	////////////////////////////////////////
	// sizing

	localparam int word_w     = 40;   // full record
	localparam int key_w      = 20;   // sort key, bits 21..2
	localparam int depth      = 5;    // number of ranks
	localparam int count_w    = 3;    // holds 0..depth
	localparam int idle_limit = 16;   // idle ready cycles before drain
	localparam int idle_w     = 5;    // holds 0..idle_limit

	////////////////////////////////////////
	// record layout

	// msb first, must add up to word_w
	typedef struct packed {
		logic [3:0]       src;    // source nibble, carried through
		logic [13:0]      spare;
		logic [key_w-1:0] key;
		logic [1:0]       tag;
	} sort_fields_t;

	// raw view for storage and output, field view for the compare
	typedef union packed {
		logic [word_w-1:0] raw;
		sort_fields_t      f;
	} sort_word_t;

endpackage

// File: verilog/sort_rank_store.sv
`timescale 1ns/1ps

module sort_rank_store (
	input  logic                                       clk,
	input  logic                                       rst_n,
	input  sort_pkg::sort_word_t                       data_in,
	input  logic                                       valid_in,
	input  logic                                       ready,
	input  logic [sort_pkg::depth-1:0]                 less_mask,
	input  logic                                       idle_expired,
	output sort_pkg::sort_word_t [sort_pkg::depth-1:0] ranks,
	output sort_pkg::sort_word_t                       data_out,
	output logic                                       valid_out,
	output logic                                       full
);

	logic [sort_pkg::count_w-1:0]               count;
	logic [sort_pkg::count_w-1:0]               count_next;
	logic [sort_pkg::depth-1:0]                 valid_mask;
	logic [sort_pkg::depth-1:0]                 hit_mask;
	int                                         ins_pos;
	sort_pkg::sort_word_t [sort_pkg::depth-1:0] rank_next;
	sort_pkg::sort_word_t                       out_next;
	logic                                       vout_next;

	assign full = (int'(count) == sort_pkg::depth);

	////////////////////////////////////////
	// insert position

	always_comb begin
		for (int i = 0; i < sort_pkg::depth; i++) begin
			valid_mask[i] = (i < int'(count));
		end
	end

	assign hit_mask = less_mask & valid_mask;

	// first occupied rank with a larger key, else just past the last entry
	always_comb begin
		logic found;

		ins_pos = int'(count);
		found   = 1'b0;
		for (int i = 0; i < sort_pkg::depth; i++) begin
			if (hit_mask[i] && !found) begin
				ins_pos = i;
				found   = 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// next ranks, count and output

	always_comb begin
		rank_next    = ranks;
		count_next   = count;
		out_next.raw = '0;
		vout_next    = 1'b0;

		if (valid_in && !full) begin
			// open a slot at ins_pos, lower ranks move down one
			for (int j = 1; j < sort_pkg::depth; j++) begin
				if (j > ins_pos) begin
					rank_next[j] = ranks[j-1];
				end
			end
			rank_next[ins_pos] = data_in;
			count_next         = count + 1'b1;
		end else if (valid_in) begin
			vout_next = 1'b1;
			if (less_mask[0]) begin
				out_next.raw = data_in.raw;        // smallest of six, passes straight through
			end else begin
				out_next.raw = ranks[0].raw;       // head leaves, newcomer sorts into the rest
				for (int j = 0; j < sort_pkg::depth - 1; j++) begin
					if (j + 1 < ins_pos) begin
						rank_next[j] = ranks[j+1];
					end
				end
				rank_next[ins_pos-1] = data_in;
			end
		end else if (idle_expired && count != '0) begin
			vout_next    = 1'b1;
			out_next.raw = ranks[0].raw;
			for (int j = 0; j < sort_pkg::depth - 1; j++) begin
				rank_next[j] = ranks[j+1];
			end
			count_next = count - 1'b1;
		end
	end

	////////////////////////////////////////
	// registers, all frozen while ready is low

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count     <= '0;
			valid_out <= 1'b0;
			data_out  <= '0;
		end else if (ready) begin
			count     <= count_next;
			valid_out <= vout_next;
			data_out  <= out_next;
		end
	end

	always_ff @(posedge clk) begin
		if (ready) begin
			ranks <= rank_next;   // entries past count are don't care
		end
	end

endmodule
